// File: console_msg.svh
/*
 * Console message ROM contents
 * Each message ends with CH_END, placeholders expand to hex in the printer
 */
`ifndef CONSOLE_MSG_SVH
`define CONSOLE_MSG_SVH

localparam int MSG_ROM_DEPTH = 68;

localparam char_t MSG_ROM [MSG_ROM_DEPTH] = '{
	// MSG_TITLE
	"D", "D", "R", "3", " ", "T", "e", "s", "t", CH_CR, CH_LF,
	"W", "a", "i", "t", " ", "i", "n", "i", "t", CH_CR, CH_LF,
	CH_END,
	// MSG_INIT_OK
	"I", "n", "i", "t", " ", "O", "K", CH_CR, CH_LF,
	"W", "r", "i", "t", "e", CH_CR, CH_LF,
	CH_END,
	// MSG_WRITE
	"W", ":", CH_ADDR, CH_CR, CH_LF,
	CH_END,
	// MSG_READ_ERR
	" ", "R", "e", "a", "d", " ", "E", "r", "r", " ",
	CH_ADDR, ":", CH_DATA, CH_CR, CH_LF,
	CH_END,
	// MSG_READ
	"R", ":", CH_ADDR, CH_CR, CH_LF,
	CH_END
};

`endif

// File: dram_test_pkg.sv
/*
 * DDR3 tester shared definitions
 * Data widths, FSM encodings, message ROM offsets and console constants
 */
`default_nettype none

package dram_test_pkg;

	// Widths that carry a meaning
	typedef logic [26:0]  dram_addr_t;
	typedef logic [15:0]  lane_word_t;
	typedef logic [127:0] beat_t;
	typedef logic [15:0]  mask_t;
	typedef logic [7:0]   char_t;
	typedef logic [6:0]   msg_ptr_t;

	localparam int         LANES     = 8;
	localparam dram_addr_t ADDR_STEP = 27'd8;
	localparam logic [7:0] UART_ADDR = 8'h10;

	// ----------------------------------------------------------------------
	// Message ROM start offsets
	// ----------------------------------------------------------------------
	localparam msg_ptr_t MSG_TITLE    = 7'd0;
	localparam msg_ptr_t MSG_INIT_OK  = 7'd23;
	localparam msg_ptr_t MSG_WRITE    = 7'd40;
	localparam msg_ptr_t MSG_READ_ERR = 7'd46;
	localparam msg_ptr_t MSG_READ     = 7'd62;

	// End code, placeholders and line break
	localparam char_t CH_END  = 8'h00;
	localparam char_t CH_ADDR = "@";
	localparam char_t CH_DATA = "#";
	localparam char_t CH_CR   = 8'h0D;
	localparam char_t CH_LF   = 8'h0A;

	// Address printed as 28 bits with a leading zero
	localparam int ADDR_DIGITS = 7;
	localparam int DATA_DIGITS = 32;

	typedef enum logic [3:0] {
		SQ_IDLE,
		SQ_TITLE,
		SQ_WAIT_INIT,
		SQ_INIT_OK,
		SQ_WR_CHECK,
		SQ_WR_MARK,
		SQ_WR_REQ,
		SQ_RD_CHECK,
		SQ_RD_MARK,
		SQ_RD_REQ,
		SQ_RD_DATA,
		SQ_RD_ERR,
		SQ_FINISH
	} seq_state_t;

	typedef enum logic [2:0] {
		PS_IDLE,
		PS_CHECK,
		PS_CHAR,
		PS_HEX,
		PS_DONE
	} print_state_t;

endpackage

`default_nettype wire

// File: print_if.sv
/*
 * Print request channel between the test sequencer and the console printer
 */
`default_nettype none

interface print_if;
	import dram_test_pkg::*;

	logic       start;
	msg_ptr_t   msg;
	dram_addr_t addr;
	logic       done;

	modport seq (output start, output msg, output addr, input done);
	modport prn (input start, input msg, input addr, output done);

endinterface

`default_nettype wire

// File: console_printer.sv
/*
 * Console printer
 * Walks a ROM message and sends it to the UART one character per handshake,
 * expanding address and data placeholders into upper case hex digits
 */
`default_nettype none

module console_printer (
	input  logic                 clk,
	input  logic                 reset_n,
	input  logic                 bus_ready,
	input  dram_test_pkg::beat_t fail_data,
	print_if.prn                 prn,
	output logic                 bus_valid,
	output dram_test_pkg::char_t bus_wdata
);
	import dram_test_pkg::*;

	`include "console_msg.svh"

	localparam int BEAT_W   = $bits(beat_t);
	localparam int ADDR_PAD = BEAT_W - 4 * ADDR_DIGITS;

	print_state_t state;
	msg_ptr_t     ptr;
	char_t        rom_char;
	beat_t        hex_shift;
	logic [5:0]   digits_left;

	function automatic char_t hex_char(input logic [3:0] nib);
		if (nib < 4'd10) begin
			return 8'h30 + char_t'(nib);
		end
		// 0x37 + 10 lands on "A"
		return 8'h37 + char_t'(nib);
	endfunction

	assign rom_char = MSG_ROM[ptr];

	// ----------------------------------------------------------------------
	// Message walker
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state     <= PS_IDLE;
			bus_valid <= 1'b0;
			prn.done  <= 1'b0;
		end else begin
			case (state)
				PS_IDLE: begin
					if (prn.start) begin
						ptr   <= prn.msg;
						state <= PS_CHECK;
					end
				end
				PS_CHECK: begin
					ptr <= ptr + 7'd1;
					case (rom_char)
						CH_END: begin
							prn.done <= 1'b1;
							state    <= PS_DONE;
						end
						CH_ADDR: begin
							// Address sits at the top, most significant digit first
							hex_shift   <= {1'b0, prn.addr, {ADDR_PAD{1'b0}}};
							digits_left <= 6'(ADDR_DIGITS);
							state       <= PS_HEX;
						end
						CH_DATA: begin
							hex_shift   <= fail_data;
							digits_left <= 6'(DATA_DIGITS);
							state       <= PS_HEX;
						end
						default: begin
							bus_wdata <= rom_char;
							bus_valid <= 1'b1;
							state     <= PS_CHAR;
						end
					endcase
				end
				PS_CHAR: begin
					if (bus_ready) begin
						bus_valid <= 1'b0;
						state     <= PS_CHECK;
					end
				end
				PS_HEX: begin
					// bus_valid doubles as the digit sub-state
					if (!bus_valid) begin
						bus_wdata <= hex_char(hex_shift[BEAT_W-1 -: 4]);
						bus_valid <= 1'b1;
					end else if (bus_ready) begin
						bus_valid   <= 1'b0;
						hex_shift   <= hex_shift << 4;
						digits_left <= digits_left - 6'd1;
						if (digits_left == 6'd1) begin
							state <= PS_CHECK;
						end
					end
				end
				PS_DONE: begin
					// Sequencer drops start on this edge
					prn.done <= 1'b0;
					state    <= PS_IDLE;
				end
				default: begin
					bus_valid <= 1'b0;
					prn.done  <= 1'b0;
					state     <= PS_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: pattern_lane.sv
/*
 * One 16-bit lane of the test pattern
 * Holds the write and expected read word, compares it with read data
 */
`default_nettype none

module pattern_lane #(
	parameter int LANE = 0
) (
	input  logic                      clk,
	input  logic                      reset_n,
	input  logic                      clear,
	input  logic                      step,
	input  dram_test_pkg::lane_word_t rdata,
	output dram_test_pkg::lane_word_t word,
	output logic                      mismatch
);
	import dram_test_pkg::*;

	// Odd increment per lane, 1, 3, 5 and so on
	localparam lane_word_t INCR = lane_word_t'(2 * LANE + 1);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			word <= '0;
		end else if (clear) begin
			word <= '0;
		end else if (step) begin
			word <= word + INCR;
		end
	end

	assign mismatch = (rdata != word);

endmodule

`default_nettype wire

// File: read_checker.sv
/*
 * Read checker
 * One registered verdict per returned beat, failing beat kept for printing
 */
`default_nettype none

module read_checker (
	input  logic                            clk,
	input  logic                            reset_n,
	input  logic                            rdata_valid,
	input  dram_test_pkg::beat_t            rdata,
	input  logic [dram_test_pkg::LANES-1:0] mismatch,
	output logic                            check_valid,
	output logic                            check_ok,
	output dram_test_pkg::beat_t            fail_data
);
	import dram_test_pkg::*;

	logic any_mismatch;

	assign any_mismatch = |mismatch;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			check_valid <= 1'b0;
			check_ok    <= 1'b0;
		end else begin
			check_valid <= rdata_valid;
			if (rdata_valid) begin
				check_ok <= !any_mismatch;
			end
		end
	end

	// Held until the next failing beat
	always_ff @(posedge clk) begin
		if (rdata_valid && any_mismatch) begin
			fail_data <= rdata;
		end
	end

endmodule

`default_nettype wire

// File: test_sequencer.sv
/*
 * Test sequencer
 * Start, init wait, write pass, read pass with error reports, then idle
 */
`default_nettype none

module test_sequencer #(
	parameter int TEST_WORDS = 64,
	parameter int MARK_BITS  = 5
) (
	input  logic                      clk,
	input  logic                      reset_n,
	input  logic [4:0]                button,
	input  logic                      sdram_init_busy,
	input  logic                      dram_ready,
	input  logic                      check_valid,
	input  logic                      check_ok,
	output dram_test_pkg::dram_addr_t dram_address,
	output logic                      dram_write,
	output logic                      dram_valid,
	output logic                      clear,
	output logic                      step,
	print_if.seq                      prn
);
	import dram_test_pkg::*;

	localparam dram_addr_t LAST_ADDR = dram_addr_t'(TEST_WORDS - 1) * ADDR_STEP;

	seq_state_t state;
	logic       mark_due;
	logic       last_beat;

	assign mark_due  = (dram_address[MARK_BITS-1:0] == '0);
	assign last_beat = (dram_address == LAST_ADDR);

	// Address only moves between messages
	assign prn.addr = dram_address;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state        <= SQ_IDLE;
			prn.start    <= 1'b0;
			dram_address <= '0;
			dram_write   <= 1'b0;
			dram_valid   <= 1'b0;
			clear        <= 1'b0;
			step         <= 1'b0;
		end else begin
			clear <= 1'b0;
			step  <= 1'b0;
			case (state)
				// --------------------------------------------------------------
				// Start and init wait
				// --------------------------------------------------------------
				SQ_IDLE: begin
					if (button != 5'b11111) begin
						prn.msg   <= MSG_TITLE;
						prn.start <= 1'b1;
						state     <= SQ_TITLE;
					end
				end
				SQ_TITLE: begin
					if (prn.done) begin
						prn.start <= 1'b0;
						state     <= SQ_WAIT_INIT;
					end
				end
				SQ_WAIT_INIT: begin
					if (!sdram_init_busy) begin
						prn.msg   <= MSG_INIT_OK;
						prn.start <= 1'b1;
						state     <= SQ_INIT_OK;
					end
				end
				SQ_INIT_OK: begin
					if (prn.done) begin
						prn.start    <= 1'b0;
						clear        <= 1'b1;
						dram_address <= '0;
						dram_write   <= 1'b1;
						state        <= SQ_WR_CHECK;
					end
				end
				// --------------------------------------------------------------
				// Write pass
				// --------------------------------------------------------------
				SQ_WR_CHECK: begin
					if (mark_due) begin
						prn.msg   <= MSG_WRITE;
						prn.start <= 1'b1;
						state     <= SQ_WR_MARK;
					end else begin
						dram_valid <= 1'b1;
						state      <= SQ_WR_REQ;
					end
				end
				SQ_WR_MARK: begin
					if (prn.done) begin
						prn.start  <= 1'b0;
						dram_valid <= 1'b1;
						state      <= SQ_WR_REQ;
					end
				end
				SQ_WR_REQ: begin
					if (dram_ready) begin
						dram_valid <= 1'b0;
						if (last_beat) begin
							// Pattern restarts from zero for the read pass
							clear        <= 1'b1;
							dram_address <= '0;
							dram_write   <= 1'b0;
							state        <= SQ_RD_CHECK;
						end else begin
							step         <= 1'b1;
							dram_address <= dram_address + ADDR_STEP;
							state        <= SQ_WR_CHECK;
						end
					end
				end
				// --------------------------------------------------------------
				// Read pass
				// --------------------------------------------------------------
				SQ_RD_CHECK: begin
					if (mark_due) begin
						prn.msg   <= MSG_READ;
						prn.start <= 1'b1;
						state     <= SQ_RD_MARK;
					end else begin
						dram_valid <= 1'b1;
						state      <= SQ_RD_REQ;
					end
				end
				SQ_RD_MARK: begin
					if (prn.done) begin
						prn.start  <= 1'b0;
						dram_valid <= 1'b1;
						state      <= SQ_RD_REQ;
					end
				end
				SQ_RD_REQ: begin
					if (dram_ready) begin
						dram_valid <= 1'b0;
						state      <= SQ_RD_DATA;
					end
				end
				SQ_RD_DATA: begin
					if (check_valid) begin
						if (check_ok) begin
							step         <= 1'b1;
							dram_address <= dram_address + ADDR_STEP;
							state        <= last_beat ? SQ_FINISH : SQ_RD_CHECK;
						end else begin
							prn.msg   <= MSG_READ_ERR;
							prn.start <= 1'b1;
							state     <= SQ_RD_ERR;
						end
					end
				end
				SQ_RD_ERR: begin
					// Report done, carry on with the next beat
					if (prn.done) begin
						prn.start    <= 1'b0;
						step         <= 1'b1;
						dram_address <= dram_address + ADDR_STEP;
						state        <= last_beat ? SQ_FINISH : SQ_RD_CHECK;
					end
				end
				SQ_FINISH: begin
					state <= SQ_FINISH;
				end
				default: begin
					prn.start  <= 1'b0;
					dram_valid <= 1'b0;
					state      <= SQ_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: dram_test_top.sv
/*
 * DDR3 memory tester top level
 * Sequencer, pattern lanes, read checker and console printer
 */
`default_nettype none

module dram_test_top #(
	parameter int TEST_WORDS = 64,
	parameter int MARK_BITS  = 5
) (
	input  logic                      clk,
	input  logic                      reset_n,
	input  logic [4:0]                button,
	input  logic                      sdram_init_busy,
	input  logic                      bus_ready,
	input  logic                      dram_ready,
	input  dram_test_pkg::beat_t      dram_rdata,
	input  logic                      dram_rdata_valid,
	output logic [7:0]                bus_address,
	output logic                      bus_valid,
	output dram_test_pkg::char_t      bus_wdata,
	output dram_test_pkg::dram_addr_t dram_address,
	output logic                      dram_write,
	output logic                      dram_valid,
	output dram_test_pkg::beat_t      dram_wdata,
	output dram_test_pkg::mask_t      dram_wdata_mask
);
	import dram_test_pkg::*;

	localparam int LANE_W = $bits(lane_word_t);

	print_if prn_bus ();

	logic             lane_clear;
	logic             lane_step;
	lane_word_t       lane_word [LANES];
	logic [LANES-1:0] lane_mismatch;
	logic             check_valid;
	logic             check_ok;
	beat_t            fail_data;

	assign bus_address     = UART_ADDR;
	assign dram_wdata_mask = '0;

	test_sequencer #(
		.TEST_WORDS (TEST_WORDS),
		.MARK_BITS  (MARK_BITS)
	) i_sequencer (
		.clk             (clk),
		.reset_n         (reset_n),
		.button          (button),
		.sdram_init_busy (sdram_init_busy),
		.dram_ready      (dram_ready),
		.check_valid     (check_valid),
		.check_ok        (check_ok),
		.dram_address    (dram_address),
		.dram_write      (dram_write),
		.dram_valid      (dram_valid),
		.clear           (lane_clear),
		.step            (lane_step),
		.prn             (prn_bus.seq)
	);

	// ----------------------------------------------------------------------
	// Pattern lanes, lane 0 in the lowest bits
	// ----------------------------------------------------------------------
	for (genvar i = 0; i < LANES; i++) begin : g_lane
		pattern_lane #(
			.LANE (i)
		) i_lane (
			.clk      (clk),
			.reset_n  (reset_n),
			.clear    (lane_clear),
			.step     (lane_step),
			.rdata    (dram_rdata[i*LANE_W +: LANE_W]),
			.word     (lane_word[i]),
			.mismatch (lane_mismatch[i])
		);
	end

	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			dram_wdata[i*LANE_W +: LANE_W] = lane_word[i];
		end
	end

	read_checker i_checker (
		.clk         (clk),
		.reset_n     (reset_n),
		.rdata_valid (dram_rdata_valid),
		.rdata       (dram_rdata),
		.mismatch    (lane_mismatch),
		.check_valid (check_valid),
		.check_ok    (check_ok),
		.fail_data   (fail_data)
	);

	console_printer i_printer (
		.clk       (clk),
		.reset_n   (reset_n),
		.bus_ready (bus_ready),
		.fail_data (fail_data),
		.prn       (prn_bus.prn),
		.bus_valid (bus_valid),
		.bus_wdata (bus_wdata)
	);

endmodule

`default_nettype wire

// File: tb_dram_model.sv
/*
 * Behavioral DDR3 controller for the tester testbench
 * Random ready delays, variable read latency and injected bit errors
 */
`default_nettype none

module tb_dram_model #(
	parameter int WORDS = 64
) (
	input  logic             clk,
	input  logic             reset_n,
	input  logic [26:0]      dram_address,
	input  logic             dram_write,
	input  logic             dram_valid,
	input  logic [127:0]     dram_wdata,
	input  logic             rnd_ready,
	input  logic [2:0]       rnd_latency,
	input  logic [2:0][15:0] err_beat,
	input  logic [2:0][6:0]  err_bit,
	output logic             dram_ready,
	output logic [127:0]     dram_rdata,
	output logic             dram_rdata_valid
);

	logic [127:0] mem [WORDS];
	logic         rd_pending;
	logic [2:0]   rd_wait;
	logic [26:0]  rd_index;

	// Bits flipped on the way out for the chosen beats
	function automatic logic [127:0] flip_mask(input logic [26:0] index);
		logic [127:0] m;
		m = '0;
		for (int k = 0; k < 3; k++) begin
			if (27'(err_beat[k]) == index) begin
				m[err_bit[k]] = 1'b1;
			end
		end
		return m;
	endfunction

	initial begin
		dram_ready       = 1'b0;
		dram_rdata       = '0;
		dram_rdata_valid = 1'b0;
		rd_pending       = 1'b0;
		rd_wait          = '0;
		rd_index         = '0;
	end

	always @(posedge clk) begin
		if (!reset_n) begin
			dram_ready       <= 1'b0;
			dram_rdata_valid <= 1'b0;
			rd_pending       <= 1'b0;
		end else begin
			dram_rdata_valid <= 1'b0;
			if (dram_valid && dram_ready) begin
				dram_ready <= 1'b0;
				if (dram_write) begin
					mem[dram_address >> 3] <= dram_wdata;
				end else begin
					rd_pending <= 1'b1;
					rd_wait    <= rnd_latency;
					rd_index   <= dram_address >> 3;
				end
			end else begin
				// Random wait before accepting
				dram_ready <= dram_valid && rnd_ready;
			end
			if (rd_pending) begin
				if (rd_wait == 3'd0) begin
					dram_rdata       <= mem[rd_index] ^ flip_mask(rd_index);
					dram_rdata_valid <= 1'b1;
					rd_pending       <= 1'b0;
				end else begin
					rd_wait <= rd_wait - 3'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_dram_test.sv
/*
 * DDR3 tester testbench
 * Random UART and memory back-pressure, checks console text and requests
 */
`default_nettype none

module tb_dram_test;

	localparam int TEST_WORDS = 64;
	localparam int MARK_BITS  = 5;
	localparam int ERR_BEATS  = 3;
	localparam int QUIET      = 200;

	logic             clk;
	logic             reset_n;
	logic [4:0]       button;
	logic             sdram_init_busy;
	logic             bus_ready;
	logic             dram_ready;
	logic [127:0]     dram_rdata;
	logic             dram_rdata_valid;
	logic [7:0]       bus_address;
	logic             bus_valid;
	logic [7:0]       bus_wdata;
	logic [26:0]      dram_address;
	logic             dram_write;
	logic             dram_valid;
	logic [127:0]     dram_wdata;
	logic [15:0]      dram_wdata_mask;
	logic             rnd_ready;
	logic [2:0]       rnd_latency;
	logic [2:0][15:0] err_beat;
	logic [2:0][6:0]  err_bit;
	logic [15:0]      lfsr;

	// Expected console text and memory requests
	logic [7:0]   exp_chars [$];
	logic         exp_write [$];
	logic [26:0]  exp_addr [$];
	logic [127:0] exp_data [$];
	// Characters expected ahead of each request
	int           exp_char_pos [$];

	int           title_len;
	int           total_chars;
	int           total_reqs;
	int           chars_seen;
	int           reqs_seen;
	int           cycles;
	int           cycle_limit;
	int           char_errors;
	int           req_errors;
	logic         pressed;
	logic         bus_waiting;
	logic [7:0]   held_char;
	logic         dram_waiting;
	logic [26:0]  held_addr;
	logic         held_write;
	logic [127:0] held_wdata;

	dram_test_top #(
		.TEST_WORDS (TEST_WORDS),
		.MARK_BITS  (MARK_BITS)
	) i_dram_test_top (
		.clk              (clk),
		.reset_n          (reset_n),
		.button           (button),
		.sdram_init_busy  (sdram_init_busy),
		.bus_ready        (bus_ready),
		.dram_ready       (dram_ready),
		.dram_rdata       (dram_rdata),
		.dram_rdata_valid (dram_rdata_valid),
		.bus_address      (bus_address),
		.bus_valid        (bus_valid),
		.bus_wdata        (bus_wdata),
		.dram_address     (dram_address),
		.dram_write       (dram_write),
		.dram_valid       (dram_valid),
		.dram_wdata       (dram_wdata),
		.dram_wdata_mask  (dram_wdata_mask)
	);

	tb_dram_model #(
		.WORDS (TEST_WORDS)
	) i_dram_model (
		.clk              (clk),
		.reset_n          (reset_n),
		.dram_address     (dram_address),
		.dram_write       (dram_write),
		.dram_valid       (dram_valid),
		.dram_wdata       (dram_wdata),
		.rnd_ready        (rnd_ready),
		.rnd_latency      (rnd_latency),
		.err_beat         (err_beat),
		.err_bit          (err_bit),
		.dram_ready       (dram_ready),
		.dram_rdata       (dram_rdata),
		.dram_rdata_valid (dram_rdata_valid)
	);

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	// Lane i of beat n counts up by 2i+1
	function automatic logic [127:0] pattern_beat(input int n);
		logic [127:0] b;
		for (int i = 0; i < 8; i++) begin
			b[16*i +: 16] = 16'(n * (2 * i + 1));
		end
		return b;
	endfunction

	function automatic logic [127:0] injected_flips(input int n);
		logic [127:0] m;
		m = '0;
		for (int k = 0; k < ERR_BEATS; k++) begin
			if (int'(err_beat[k]) == n) begin
				m[err_bit[k]] = 1'b1;
			end
		end
		return m;
	endfunction

	function automatic logic [7:0] hex_digit(input logic [3:0] nib);
		string digits;
		digits = "0123456789ABCDEF";
		return digits[nib];
	endfunction

	task automatic push_text(input string s);
		for (int i = 0; i < s.len(); i++) begin
			exp_chars.push_back(s[i]);
		end
	endtask

	task automatic push_eol();
		exp_chars.push_back(8'h0D);
		exp_chars.push_back(8'h0A);
	endtask

	task automatic push_hex(input logic [127:0] v, input int count);
		for (int d = count - 1; d >= 0; d--) begin
			exp_chars.push_back(hex_digit(v[4*d +: 4]));
		end
	endtask

	// ----------------------------------------------------------------------
	// Reference model of the whole run
	// ----------------------------------------------------------------------
	task automatic build_reference();
		logic [26:0] addr;
		push_text("DDR3 Test");
		push_eol();
		push_text("Wait init");
		push_eol();
		title_len = exp_chars.size();
		push_text("Init OK");
		push_eol();
		push_text("Write");
		push_eol();
		for (int n = 0; n < TEST_WORDS; n++) begin
			addr = 27'(n * 8);
			if (addr % (1 << MARK_BITS) == 0) begin
				push_text("W:");
				push_hex(128'(addr), 7);
				push_eol();
			end
			exp_write.push_back(1'b1);
			exp_addr.push_back(addr);
			exp_data.push_back(pattern_beat(n));
			exp_char_pos.push_back(exp_chars.size());
		end
		for (int n = 0; n < TEST_WORDS; n++) begin
			addr = 27'(n * 8);
			if (addr % (1 << MARK_BITS) == 0) begin
				push_text("R:");
				push_hex(128'(addr), 7);
				push_eol();
			end
			exp_write.push_back(1'b0);
			exp_addr.push_back(addr);
			exp_data.push_back('0);
			exp_char_pos.push_back(exp_chars.size());
			if (injected_flips(n) != '0) begin
				push_text(" Read Err ");
				push_hex(128'(addr), 7);
				push_text(":");
				push_hex(pattern_beat(n) ^ injected_flips(n), 32);
				push_eol();
			end
		end
		total_chars = exp_chars.size();
		total_reqs  = exp_write.size();
	endtask

	task automatic check_char();
		logic [7:0] exp;
		if (exp_chars.size() == 0) begin
			char_errors++;
			$display("ERROR: unexpected character on the UART, bus_wdata %h", bus_wdata);
		end else begin
			exp = exp_chars.pop_front();
			if (bus_wdata !== exp) begin
				char_errors++;
				$display("ERROR: bus_wdata %h, expected %h (character %0d)",
					bus_wdata, exp, chars_seen);
			end
		end
		if (bus_address !== 8'h10) begin
			char_errors++;
			$display("ERROR: bus_address %h, expected %h", bus_address, 8'h10);
		end
		if (sdram_init_busy && chars_seen >= title_len) begin
			char_errors++;
			$display("Character sent while memory init was still busy");
		end
	endtask

	task automatic check_request();
		logic         wr;
		logic [26:0]  addr;
		logic [127:0] data;
		int           pos;
		if (exp_write.size() == 0) begin
			req_errors++;
			$display("ERROR: unexpected request, dram_address %h", dram_address);
		end else begin
			wr   = exp_write.pop_front();
			addr = exp_addr.pop_front();
			data = exp_data.pop_front();
			pos  = exp_char_pos.pop_front();
			if (dram_write !== wr) begin
				req_errors++;
				$display("ERROR: dram_write %h, expected %h", dram_write, wr);
			end
			if (dram_address !== addr) begin
				req_errors++;
				$display("ERROR: dram_address %h, expected %h", dram_address, addr);
			end
			if (wr && dram_wdata !== data) begin
				req_errors++;
				$display("ERROR: dram_wdata %h, expected %h", dram_wdata, data);
			end
			if (chars_seen != pos) begin
				req_errors++;
				$display("Request %0d issued after %0d characters, expected after %0d",
					reqs_seen, chars_seen, pos);
			end
		end
		if (dram_wdata_mask !== 16'h0) begin
			req_errors++;
			$display("ERROR: dram_wdata_mask %h, expected %h", dram_wdata_mask, 16'h0);
		end
	endtask

	task automatic report_counts();
		$display("Errors: %0d on the UART, %0d on the memory port", char_errors, req_errors);
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Per-cycle back-pressure and read latency
	always @(posedge clk) begin
		bus_ready   <= (rand_bits(2) != 0);
		rnd_ready   <= 1'(rand_bits(1));
		rnd_latency <= 3'(rand_bits(3));
	end

	// ----------------------------------------------------------------------
	// Monitors
	// ----------------------------------------------------------------------
	always @(posedge clk) begin
		if (reset_n) begin
			if (!pressed && bus_valid) begin
				char_errors++;
				$display("UART output started before any button was pressed");
			end
			if (bus_waiting && (!bus_valid || bus_wdata !== held_char)) begin
				char_errors++;
				$display("ERROR: bus_wdata %h, held %h before bus_ready", bus_wdata, held_char);
			end
			if (bus_valid && bus_ready) begin
				check_char();
				chars_seen <= chars_seen + 1;
			end
		end
		bus_waiting <= reset_n && bus_valid && !bus_ready;
		held_char   <= bus_wdata;
	end

	always @(posedge clk) begin
		if (reset_n) begin
			if (dram_valid && (!pressed || sdram_init_busy)) begin
				req_errors++;
				$display("Memory request issued before the press or during init");
			end
			if (dram_waiting && (!dram_valid || dram_address !== held_addr ||
				dram_write !== held_write || dram_wdata !== held_wdata)) begin
				req_errors++;
				$display("ERROR: dram_address %h dram_wdata %h changed before dram_ready",
					dram_address, dram_wdata);
			end
			if (dram_valid && dram_ready) begin
				check_request();
				reqs_seen <= reqs_seen + 1;
			end
		end
		dram_waiting <= reset_n && dram_valid && !dram_ready;
		held_addr    <= dram_address;
		held_write   <= dram_write;
		held_wdata   <= dram_wdata;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, %0d of %0d characters, %0d of %0d requests",
				cycles, chars_seen, total_chars, reqs_seen, total_reqs);
			report_counts();
			$display("** FAIL **");
			$finish;
		end
	end

	initial begin
		int busy_len;
		int press_bit;
		reset_n         = 1'b0;
		button          = 5'b11111;
		sdram_init_busy = 1'b1;
		bus_ready       = 1'b0;
		rnd_ready       = 1'b0;
		rnd_latency     = '0;
		lfsr            = 16'd87;
		pressed         = 1'b0;
		bus_waiting     = 1'b0;
		held_char       = '0;
		dram_waiting    = 1'b0;
		held_addr       = '0;
		held_write      = 1'b0;
		held_wdata      = '0;
		chars_seen      = 0;
		reqs_seen       = 0;
		cycles          = 0;
		cycle_limit     = 0;
		char_errors     = 0;
		req_errors      = 0;
		// One flipped bit in each third of the range
		for (int k = 0; k < ERR_BEATS; k++) begin
			err_beat[k] = 16'(k * (TEST_WORDS / ERR_BEATS) +
				rand_bits(5) % (TEST_WORDS / ERR_BEATS));
			err_bit[k]  = 7'(rand_bits(7));
		end
		busy_len  = 10 + rand_bits(6);
		press_bit = rand_bits(3) % 5;
		build_reference();
		cycle_limit = 60 + busy_len + QUIET + total_chars * 12 + total_reqs * 40;

		repeat (2) @(posedge clk);
		reset_n <= 1'b1;
		// Tester stays silent while the buttons are released
		repeat (20) @(posedge clk);
		button  <= ~(5'd1 << press_bit);
		pressed <= 1'b1;
		repeat (3) @(posedge clk);
		button <= 5'b11111;

		while (chars_seen < title_len) @(posedge clk);
		repeat (busy_len) @(posedge clk);
		sdram_init_busy <= 1'b0;

		while (chars_seen < total_chars || reqs_seen < total_reqs) @(posedge clk);
		repeat (QUIET) @(posedge clk);
		report_counts();
		if (char_errors + req_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
dram_test_pkg.sv
print_if.sv
+incdir+.
console_printer.sv
pattern_lane.sv
read_checker.sv
test_sequencer.sv
dram_test_top.sv
tb_dram_model.sv
tb_dram_test.sv
